// File: all.f
logic/rom_sched_pkg.sv
logic/rom_slot_ctrl.sv
logic/rom_addr_gen.sv
logic/rom_data_demux.sv
logic/rom_sched_top.sv
test/sdram_rom_model.sv
test/rom_sched_tb.sv

// File: logic/rom_addr_gen.sv
// address datapath of the ROM scheduler, maps the issued slot's client address into SDRAM space
`timescale 1ns/1ns

module rom_addr_gen (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               tick,        // cen12 while running
    input  logic                               clear,
    input  logic [rom_sched_pkg::slot_w-1:0]   issue_slot,
    input  logic [14:0]                        snd_addr,    // byte address
    input  logic [16:0]                        main_addr,   // byte address
    input  logic [12:0]                        char_addr,
    input  logic [15:0]                        obj_addr,
    input  logic [14:0]                        scr_addr,
    output logic [rom_sched_pkg::sdram_aw-1:0] sdram_addr,
    output logic                               snd_lsb,     // byte select for sound
    output logic                               main_lsb     // byte select for main
);

    logic [1:0] lane;  // low slot bits pick the CPU slots

    assign lane = issue_slot[1:0];

    // word address, registered on ticks only
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sdram_addr <= '0;
        end else if (clear) begin
            sdram_addr <= '0;
        end else if (tick) begin
            if (lane == rom_sched_pkg::lane_snd) begin
                // 16-bit words hold two sound ROM bytes
                sdram_addr <= rom_sched_pkg::snd_offset + {8'd0, snd_addr[14:1]};
            end else if (lane == rom_sched_pkg::lane_main) begin
                sdram_addr <= {6'd0, main_addr[16:1]};  // main ROM sits at zero
            end else begin
                case (issue_slot)
                    rom_sched_pkg::slot_char: begin
                        sdram_addr <= rom_sched_pkg::char_offset + {9'd0, char_addr};
                    end
                    rom_sched_pkg::slot_obj_a,
                    rom_sched_pkg::slot_obj_b: begin
                        sdram_addr <= rom_sched_pkg::obj_offset + {6'd0, obj_addr};
                    end
                    rom_sched_pkg::slot_scr_lo: begin
                        sdram_addr <= rom_sched_pkg::scr_offset + {7'd0, scr_addr};  // B/C ROMs
                    end
                    rom_sched_pkg::slot_scr_hi: begin
                        // E ROM word is a fixed distance above the B/C word just issued
                        sdram_addr <= sdram_addr + rom_sched_pkg::scr2_offset;
                    end
                    default: begin
                        sdram_addr <= sdram_addr;  // idle and refresh slots keep the address
                    end
                endcase
            end
        end
    end

    // byte selects travel with the request to the capture side
    // they only matter once the matching word comes back
    always_ff @(posedge clk) begin
        if (tick && lane == rom_sched_pkg::lane_snd) begin
            snd_lsb <= snd_addr[0];
        end
        if (tick && lane == rom_sched_pkg::lane_main) begin
            main_lsb <= main_addr[0];
        end
    end

    // the E ROM read reuses the B/C address of the slot before it
    a_scr_hi_addr: assert property (
        @(posedge clk) disable iff (!arst_n)
        (tick && issue_slot == rom_sched_pkg::slot_scr_hi)
            |=> sdram_addr == $past(sdram_addr) + rom_sched_pkg::scr2_offset
    );

endmodule

// File: logic/rom_data_demux.sv
// capture datapath of the ROM scheduler, steers each returned SDRAM word to its client register
`timescale 1ns/1ns

module rom_data_demux (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             tick,          // cen12 while running
    input  logic                             clear,
    input  logic [rom_sched_pkg::slot_w-1:0] capture_slot,  // slot the word belongs to
    input  rom_sched_pkg::sdram_word_u       data_read,
    input  logic                             snd_lsb,
    input  logic                             main_lsb,
    output logic [7:0]                       snd_dout,
    output logic [7:0]                       main_dout,
    output logic [15:0]                      char_dout,
    output logic [15:0]                      obj_dout,
    output logic [23:0]                      scr_dout
);

    logic [1:0]  lane;     // low slot bits, CPU slot decode
    logic [15:0] scr_aux;  // B/C word waiting for its E byte
    logic [7:0]  snd_byte;
    logic [7:0]  main_byte;
    logic [7:0]  scr_e_byte;

    assign lane = capture_slot[1:0];

    // even byte address lives in the upper half of the word
    assign snd_byte  = snd_lsb  ? data_read.bytes.lo : data_read.bytes.hi;
    assign main_byte = main_lsb ? data_read.bytes.lo : data_read.bytes.hi;

    // E ROM fills one half of the word and leaves the other zero
    assign scr_e_byte = data_read.bytes.hi | data_read.bytes.lo;

    // client outputs
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            snd_dout  <= '0;
            main_dout <= '0;
            char_dout <= '0;
            obj_dout  <= '0;
            scr_dout  <= '0;
        end else if (clear) begin
            snd_dout  <= '0;
            main_dout <= '0;
            char_dout <= '0;
            obj_dout  <= '0;
            scr_dout  <= '0;
        end else if (tick) begin
            if (lane == rom_sched_pkg::lane_snd) begin
                snd_dout <= snd_byte;
            end else if (lane == rom_sched_pkg::lane_main) begin
                main_dout <= main_byte;
            end else begin
                case (capture_slot)
                    rom_sched_pkg::slot_char: begin
                        char_dout <= data_read.word;
                    end
                    rom_sched_pkg::slot_obj_a,
                    rom_sched_pkg::slot_obj_b: begin
                        obj_dout <= data_read.word;  // two object reads per loop
                    end
                    rom_sched_pkg::slot_scr_hi: begin
                        scr_dout <= {scr_e_byte, scr_aux};  // E, then B/C bytes
                    end
                    default: begin
                        scr_dout <= scr_dout;  // scroll low and idle slots
                    end
                endcase
            end
        end
    end

    // scroll low half, picked up one slot ahead of the E byte
    always_ff @(posedge clk) begin
        if (tick && capture_slot == rom_sched_pkg::slot_scr_lo) begin
            scr_aux <= data_read.word;
        end
    end

    // memory side must honour the half-empty E ROM layout
    a_scr_hi_byte_zero: assert property (
        @(posedge clk) disable iff (!arst_n)
        (tick && capture_slot == rom_sched_pkg::slot_scr_hi)
            |-> (data_read.bytes.hi == 8'd0 || data_read.bytes.lo == 8'd0)
    );

endmodule

// File: logic/rom_sched_pkg.sv
// shared slot map, SDRAM region offsets and word view types for the ROM read scheduler
package rom_sched_pkg;

    // sizes
    localparam int sdram_aw  = 22;  // SDRAM word address width
    localparam int slot_w    = 4;   // 16 slots per schedule loop
    localparam int ready_dly = 5;   // clocks from first tick to ready

    // fixed slots, all others are decoded by their low two bits
    localparam logic [slot_w-1:0] slot_char    = 4'd2;
    localparam logic [slot_w-1:0] slot_obj_a   = 4'd3;
    localparam logic [slot_w-1:0] slot_obj_b   = 4'd11;
    localparam logic [slot_w-1:0] slot_scr_lo  = 4'd6;   // B/C ROM word
    localparam logic [slot_w-1:0] slot_scr_hi  = 4'd7;   // E ROM byte
    localparam logic [slot_w-1:0] slot_refresh = 4'd14;

    // low two slot bits that hand a slot to a byte-wide CPU
    localparam logic [1:0] lane_snd  = 2'b00;  // every fourth slot, from 0
    localparam logic [1:0] lane_main = 2'b01;  // every fourth slot, from 1

    // SDRAM memory map, word addresses
    // main CPU ROM starts at zero
    localparam logic [sdram_aw-1:0] snd_offset  = 22'h0A000;
    localparam logic [sdram_aw-1:0] char_offset = 22'h0E000;
    localparam logic [sdram_aw-1:0] scr_offset  = 22'h10000;
    localparam logic [sdram_aw-1:0] scr2_offset = 22'h08000;  // B/C word to its E word
    localparam logic [sdram_aw-1:0] obj_offset  = 22'h20000;

    // one SDRAM word split into its two bytes
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } sdram_bytes_t;

    // the returned word, seen whole by the word clients
    // and byte by byte by the CPUs and the scroll upper byte
    typedef union packed {
        logic [15:0]  word;
        sdram_bytes_t bytes;
    } sdram_word_u;

endpackage

// File: logic/rom_sched_top.sv
// top level of the time-slotted ROM read scheduler, joins slot control, address and data paths
`timescale 1ns/1ns

module rom_sched_top (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               cen12,
    input  logic [2:0]                         H,
    input  logic                               Hsub,
    input  logic [14:0]                        snd_addr,
    input  logic [16:0]                        main_addr,
    input  logic [12:0]                        char_addr,
    input  logic [15:0]                        obj_addr,
    input  logic [14:0]                        scr_addr,
    input  logic                               downloading,
    input  logic                               loop_rst,
    input  rom_sched_pkg::sdram_word_u         data_read,    // word for last sdram_addr
    output logic [rom_sched_pkg::sdram_aw-1:0] sdram_addr,
    output logic                               autorefresh,
    output logic                               ready,
    output logic [7:0]                         snd_dout,
    output logic [7:0]                         main_dout,
    output logic [15:0]                        char_dout,
    output logic [15:0]                        obj_dout,
    output logic [23:0]                        scr_dout
);

    logic [rom_sched_pkg::slot_w-1:0] issue_slot;
    logic [rom_sched_pkg::slot_w-1:0] capture_slot;
    logic                             tick;
    logic                             clear;
    logic                             snd_lsb;
    logic                             main_lsb;

    rom_slot_ctrl u_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .cen12        (cen12),
        .H            (H),
        .Hsub         (Hsub),
        .downloading  (downloading),
        .loop_rst     (loop_rst),
        .issue_slot   (issue_slot),
        .capture_slot (capture_slot),
        .tick         (tick),
        .clear        (clear),
        .autorefresh  (autorefresh),
        .ready        (ready)
    );

    rom_addr_gen u_addr (
        .clk        (clk),
        .arst_n     (arst_n),
        .tick       (tick),
        .clear      (clear),
        .issue_slot (issue_slot),
        .snd_addr   (snd_addr),
        .main_addr  (main_addr),
        .char_addr  (char_addr),
        .obj_addr   (obj_addr),
        .scr_addr   (scr_addr),
        .sdram_addr (sdram_addr),
        .snd_lsb    (snd_lsb),
        .main_lsb   (main_lsb)
    );

    rom_data_demux u_demux (
        .clk          (clk),
        .arst_n       (arst_n),
        .tick         (tick),
        .clear        (clear),
        .capture_slot (capture_slot),
        .data_read    (data_read),
        .snd_lsb      (snd_lsb),
        .main_lsb     (main_lsb),
        .snd_dout     (snd_dout),
        .main_dout    (main_dout),
        .char_dout    (char_dout),
        .obj_dout     (obj_dout),
        .scr_dout     (scr_dout)
    );

endmodule

// File: logic/rom_slot_ctrl.sv
// slot sequencer for the ROM scheduler, derives issue/capture slots, run state, ready and refresh
`timescale 1ns/1ns

module rom_slot_ctrl (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               cen12,        // 12 MHz strobe
    input  logic [2:0]                         H,            // pixel counter, low bits
    input  logic                               Hsub,         // half pixel
    input  logic                               downloading,  // ROM load in progress
    input  logic                               loop_rst,
    output logic [rom_sched_pkg::slot_w-1:0]   issue_slot,
    output logic [rom_sched_pkg::slot_w-1:0]   capture_slot,
    output logic                               tick,
    output logic                               clear,
    output logic                               autorefresh,
    output logic                               ready
);

    logic                                pre_ready;  // first tick since clear seen
    logic [rom_sched_pkg::ready_dly-1:0] ready_sr;   // ready delay chain

    // slot runs one ahead of the pixel counter so the word
    // arrives roughly at pixel 0 of each 8-pixel group
    assign issue_slot = {H, Hsub} + 4'd1;

    assign clear = loop_rst | downloading;
    assign tick  = cen12 & ~clear;  // schedule only advances while running

    // H/Hsub step together with cen12 going high, so the slot seen one
    // clock before a tick is the one issued at the previous tick
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            capture_slot <= '0;
        end else begin
            capture_slot <= issue_slot;  // every clock, not just ticks
        end
    end

    // refresh request and the start-of-loop flag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            autorefresh <= 1'b0;
            pre_ready   <= 1'b0;
        end else if (clear) begin
            autorefresh <= 1'b0;
            pre_ready   <= 1'b0;
        end else if (tick) begin
            autorefresh <= (issue_slot == rom_sched_pkg::slot_refresh);  // one tick period
            pre_ready   <= 1'b1;
        end
    end

    // ready trails pre_ready by ready_dly clocks
    // a download drops it at once, a loop reset lets it drain
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_sr <= '0;
        end else if (downloading) begin
            ready_sr <= '0;
        end else begin
            ready_sr <= {ready_sr[rom_sched_pkg::ready_dly-2:0], pre_ready};
        end
    end

    assign ready = ready_sr[rom_sched_pkg::ready_dly-1];

    // no refresh request survives a clear once the board is not ready
    a_no_refresh_in_clear: assert property (
        @(posedge clk) disable iff (!arst_n)
        (clear && !ready) |=> !autorefresh
    );

    // ready gone one clock into a download
    a_ready_drops: assert property (
        @(posedge clk) disable iff (!arst_n)
        downloading |=> !ready
    );

endmodule

// File: test/rom_sched_tb.sv
// self-checking testbench for the ROM read scheduler, random client addresses against a hashed SDRAM
`timescale 1ns/1ns

module rom_sched_tb;

    localparam int frame_clks     = 32;  // 16 slots, one tick every second clock
    localparam int timeout_cycles = 40 * frame_clks + 200;
    localparam int ready_limit    = 20;

    logic                       clk, arst_n, cen12, Hsub, downloading, loop_rst;
    logic [2:0]                 H;
    logic [14:0]                snd_addr, scr_addr;
    logic [16:0]                main_addr;
    logic [12:0]                char_addr;
    logic [15:0]                obj_addr, char_dout, obj_dout;
    logic [21:0]                sdram_addr;
    logic                       autorefresh, ready;
    logic [7:0]                 snd_dout, main_dout;
    logic [23:0]                scr_dout;
    rom_sched_pkg::sdram_word_u data_read;
    logic [3:0]                 pix;                  // {H, Hsub} as driven
    logic [3:0]                 issued_slot   = 4'd0; // slot issued at the last tick
    int                         refresh_count = 0;
    int                         cycle_count   = 0;
    int                         error_count   = 0;
    logic [31:0]                rnd;

    rom_sched_top dut_i (.*);

    sdram_rom_model rom_i (.clk(clk), .arst_n(arst_n), .addr(sdram_addr), .dout(data_read));

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // expected memory content, hashed word with the E ROM half zeroed
    function automatic rom_sched_pkg::sdram_word_u rom_word(input logic [21:0] a);
        rom_sched_pkg::sdram_word_u w;
        logic [31:0]                h;
        logic [21:0]                e_base;
        e_base = rom_sched_pkg::scr_offset + rom_sched_pkg::scr2_offset;
        h      = ({10'd0, a} ^ 32'h5bd1e995) * 32'h2c1b3c6d;
        w.word = h[31:16] ^ h[15:0];
        if (a >= e_base && a < e_base + 22'h08000) begin
            if (a[0]) begin
                w.bytes.hi = 8'd0;
            end else begin
                w.bytes.lo = 8'd0;
            end
        end
        return w;
    endfunction

    function automatic logic [7:0] ref_snd(input logic [14:0] a);
        rom_sched_pkg::sdram_word_u w;
        w = rom_word(rom_sched_pkg::snd_offset + {8'd0, a[14:1]});
        return a[0] ? w.bytes.lo : w.bytes.hi;  // even byte sits in the upper half
    endfunction

    function automatic logic [7:0] ref_main(input logic [16:0] a);
        rom_sched_pkg::sdram_word_u w;
        w = rom_word({6'd0, a[16:1]});  // main ROM at zero
        return a[0] ? w.bytes.lo : w.bytes.hi;
    endfunction

    function automatic rom_sched_pkg::sdram_word_u ref_char(input logic [12:0] a);
        return rom_word(rom_sched_pkg::char_offset + {9'd0, a});
    endfunction

    function automatic rom_sched_pkg::sdram_word_u ref_obj(input logic [15:0] a);
        return rom_word(rom_sched_pkg::obj_offset + {6'd0, a});
    endfunction

    function automatic logic [23:0] ref_scr(input logic [14:0] a);
        logic [21:0]                bc_addr;
        logic [21:0]                e_addr;
        rom_sched_pkg::sdram_word_u bc;
        rom_sched_pkg::sdram_word_u e;
        bc_addr = rom_sched_pkg::scr_offset + {7'd0, a};
        e_addr  = bc_addr + rom_sched_pkg::scr2_offset;
        bc      = rom_word(bc_addr);
        e       = rom_word(e_addr);
        return {e_addr[0] ? e.bytes.lo : e.bytes.hi, bc.word};  // kept E byte over B/C word
    endfunction

    task automatic stop_run(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %0t ns: %s is %02h, expected %02h", $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input rom_sched_pkg::sdram_word_u got,
                              input rom_sched_pkg::sdram_word_u exp);
        if (got.word !== exp.word) begin
            stop_run($sformatf("FAIL %0t ns: %s is %04h, expected %04h", $time, name,
                               got.word, exp.word));
        end
    endtask

    task automatic check_scr(input logic [23:0] got, input logic [23:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %0t ns: scr_dout is %06h, expected %06h", $time, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input logic [21:0] got, input logic [21:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %0t ns: %s is %06h, expected %06h", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %0t ns: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    // one clock, inputs change 10 ns after the edge
    task automatic step();
        @(posedge clk);
        #10;
        cen12 = ~cen12;
        if (cen12) begin
            pix = pix + 4'd1;  // pixel counter moves with the tick strobe
        end
        H    = pix[3:1];
        Hsub = pix[0];
    endtask

    // stop where the coming tick issues slot 0
    task automatic next_frame();
        step();
        while (!(cen12 && pix == 4'd15)) begin
            step();
        end
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!ready && waited < ready_limit) begin
            step();
            waited++;
        end
        if (!ready) begin
            stop_run($sformatf("ready did not rise within %0d clocks of the first tick",
                               ready_limit));
        end
    endtask

    task automatic check_clients();
        check_byte("snd_dout", snd_dout, ref_snd(snd_addr));
        check_byte("main_dout", main_dout, ref_main(main_addr));
        check_word("char_dout", char_dout, ref_char(char_addr));
        check_word("obj_dout", obj_dout, ref_obj(obj_addr));
        check_scr(scr_dout, ref_scr(scr_addr));
    endtask

    task automatic check_idle();
        check_byte("snd_dout", snd_dout, 8'd0);
        check_byte("main_dout", main_dout, 8'd0);
        check_word("char_dout", char_dout, 16'd0);
        check_word("obj_dout", obj_dout, 16'd0);
        check_scr(scr_dout, 24'd0);
        check_flag("autorefresh", autorefresh, 1'b0);
    endtask

    // new addresses at a frame start, held two frames, then every client is compared
    task automatic run_check_cycle(input int idx);
        int mark;
        rnd          = $urandom();
        snd_addr     = rnd[14:0];
        rnd          = $urandom();
        main_addr    = rnd[16:0];
        rnd          = $urandom();
        char_addr    = rnd[12:0];
        rnd          = $urandom();
        obj_addr     = rnd[15:0];
        rnd          = $urandom();
        scr_addr     = rnd[14:0];
        snd_addr[0]  = idx[0];   // alternate byte lanes
        main_addr[0] = ~idx[0];
        repeat (2) begin
            mark = refresh_count;
            next_frame();
            if (refresh_count == mark) begin
                stop_run($sformatf("no autorefresh was seen in the frame ending at %0t ns", $time));
            end
        end
        check_clients();
    endtask

    // slot tracking and run limit, sampled before the inputs move
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cen12) begin
            issued_slot <= {H, Hsub} + 4'd1;
        end
        if (cycle_count >= timeout_cycles) begin
            stop_run($sformatf("timeout, the run did not finish within %0d clocks",
                               timeout_cycles));
        end
    end

    // refresh only after slot 14, which leaves the main address in place
    always @(negedge clk) begin
        if (arst_n && autorefresh) begin
            refresh_count <= refresh_count + 1;
            if (issued_slot != rom_sched_pkg::slot_refresh) begin
                stop_run($sformatf("FAIL %0t ns: autorefresh high after slot %0d", $time,
                                   issued_slot));
            end
            check_addr("sdram_addr in refresh period", sdram_addr, {6'd0, main_addr[16:1]});
        end
    end

    initial begin
        arst_n      = 1'b0;
        cen12       = 1'b0;
        pix         = 4'd0;
        H           = 3'd0;
        Hsub        = 1'b0;
        snd_addr    = '0;
        main_addr   = '0;
        char_addr   = '0;
        obj_addr    = '0;
        scr_addr    = '0;
        downloading = 1'b0;
        loop_rst    = 1'b0;
        rnd         = $urandom(32'h6f591178);  // one seed for the whole run
        repeat (10) step();
        next_frame();
        arst_n = 1'b1;  // first tick will issue slot 0
        check_flag("ready after reset", ready, 1'b0);
        wait_ready();
        next_frame();
        for (int i = 0; i < 6; i++) begin
            run_check_cycle(i);
        end
        downloading = 1'b1;  // ROM reload over one frame
        step();
        step();
        check_flag("ready during download", ready, 1'b0);
        next_frame();
        check_idle();
        check_flag("ready during download", ready, 1'b0);
        downloading = 1'b0;
        wait_ready();
        next_frame();
        run_check_cycle(6);
        run_check_cycle(7);
        while (!autorefresh) begin
            step();  // move into the refresh period after slot 14
        end
        loop_rst = 1'b1;  // short loop reset while the refresh request is up
        repeat (4) step();
        check_idle();
        loop_rst = 1'b0;
        next_frame();
        for (int i = 8; i < 12; i++) begin
            run_check_cycle(i);
        end
        if (error_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1);
        end
    end

endmodule

// File: test/sdram_rom_model.sv
// behavioral SDRAM for the ROM scheduler testbench, hashed content per address, one clock read latency
`timescale 1ns/1ns

module sdram_rom_model (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic [rom_sched_pkg::sdram_aw-1:0] addr,
    output rom_sched_pkg::sdram_word_u         dout
);

    // scroll E ROM, one byte of each word is left empty
    localparam logic [rom_sched_pkg::sdram_aw-1:0] e_base =
        rom_sched_pkg::scr_offset + rom_sched_pkg::scr2_offset;

    function automatic logic [15:0] content(input logic [rom_sched_pkg::sdram_aw-1:0] a);
        logic [31:0] h;
        logic [15:0] w;
        h = ({10'd0, a} ^ 32'h5bd1e995) * 32'h2c1b3c6d;  // cheap address scramble
        w = h[31:16] ^ h[15:0];
        if (a >= e_base && a < e_base + 22'h08000) begin
            if (a[0]) begin
                w[15:8] = 8'd0;  // odd words keep the low byte
            end else begin
                w[7:0] = 8'd0;   // even words keep the high byte
            end
        end
        return w;
    endfunction

    // word for the address seen at the previous edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dout <= '0;
        end else begin
            dout <= content(addr);
        end
    end

endmodule
